// File: dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Geometry
`define DC_DATA_W      32
`define DC_WORDS       4
`define DC_WAYS        2
`define DC_SETS        128

// Address split: tag 31..11, index 10..4, word 3..2, byte 1..0
`define DC_TAG_W       21
`define DC_INDEX_W     7
`define DC_OFFSET_W    2

// Backing memory
`define DC_MEM_LATENCY 2
`define DC_MEM_BLOCKS  1024

`endif

// File: dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    // RV funct3 encoding of load/store width
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } access_size_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } cpu_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL,
        S_DONE
    } ctrl_state_e;

    typedef struct packed {
        cpu_op_e                op;
        access_size_e           size;
        logic [`DC_DATA_W-1:0]  addr;
        logic [`DC_DATA_W-1:0]  wdata;
    } cpu_req_t;

    // One whole block per memory command
    typedef struct packed {
        logic                             write;
        logic [`DC_DATA_W-1:0]            addr;
        logic [`DC_DATA_W*`DC_WORDS-1:0]  data;
    } mem_req_t;

endpackage

// File: dcache_align.sv
`timescale 1ns/1ns

module dcache_align (
    input  dcache_pkg::access_size_e size,
    input  logic [1:0]               byte_off,
    input  logic [31:0]              word_in,
    input  logic [31:0]              store_data,
    output logic [31:0]              load_data,
    output logic [31:0]              merged_word
);
    import dcache_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Halfwords use only bit 1 of the offset
    assign byte_sel = word_in[{byte_off, 3'b000} +: 8];
    assign half_sel = word_in[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            SIZE_B: begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            SIZE_H: begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            SIZE_BU: begin
                load_data = {24'b0, byte_sel};
            end
            SIZE_HU: begin
                load_data = {16'b0, half_sel};
            end
            default: begin
                load_data = word_in;
            end
        endcase
    end

    always_comb begin
        merged_word = word_in;
        case (size)
            SIZE_B, SIZE_BU: begin
                merged_word[{byte_off, 3'b000} +: 8] = store_data[7:0];
            end
            SIZE_H, SIZE_HU: begin
                merged_word[{byte_off[1], 4'b0000} +: 16] = store_data[15:0];
            end
            default: begin
                merged_word = store_data;
            end
        endcase
    end

endmodule

// File: dcache_arrays.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_arrays (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [`DC_DATA_W-1:0]            lookup_addr,
    output logic                             hit,
    output logic                             hit_way,
    output logic [`DC_DATA_W-1:0]            hit_word,
    output logic                             victim_way,
    output logic                             victim_dirty,
    output logic [`DC_DATA_W-1:0]            victim_addr,
    output logic [`DC_DATA_W*`DC_WORDS-1:0]  victim_block,
    input  logic                             fill_en,
    input  logic                             fill_way,
    input  logic [`DC_DATA_W*`DC_WORDS-1:0]  fill_block,
    input  logic                             fill_dirty,
    input  logic                             word_wr_en,
    input  logic                             word_way,
    input  logic [`DC_DATA_W-1:0]            word_data
);

    logic [`DC_TAG_W-1:0]            tag;
    logic [`DC_INDEX_W-1:0]          index;
    logic [`DC_OFFSET_W-1:0]         offset;

    logic [`DC_TAG_W-1:0]            tag_mem  [`DC_SETS][`DC_WAYS];
    logic [`DC_DATA_W*`DC_WORDS-1:0] data_mem [`DC_SETS][`DC_WAYS];

    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    // One round-robin bit per set
    logic [`DC_SETS-1:0]               victim_q;

    assign tag    = lookup_addr[`DC_DATA_W-1 -: `DC_TAG_W];
    assign index  = lookup_addr[`DC_OFFSET_W+2 +: `DC_INDEX_W];
    assign offset = lookup_addr[2 +: `DC_OFFSET_W];

    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (valid_q[index][w] && tag_mem[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = 1'(w);
            end
        end
    end

    assign hit_word = data_mem[index][hit_way][offset*`DC_DATA_W +: `DC_DATA_W];

    assign victim_way   = victim_q[index];
    assign victim_dirty = valid_q[index][victim_way] & dirty_q[index][victim_way];
    assign victim_block = data_mem[index][victim_way];
    assign victim_addr  = {tag_mem[index][victim_way], index, {(`DC_OFFSET_W+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else if (fill_en) begin
            valid_q[index][fill_way] <= 1'b1;
            dirty_q[index][fill_way] <= fill_dirty;
            victim_q[index]          <= ~victim_q[index];
        end else if (word_wr_en) begin
            dirty_q[index][word_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index][fill_way]  <= tag;
            data_mem[index][fill_way] <= fill_block;
        end else if (word_wr_en) begin
            data_mem[index][word_way][offset*`DC_DATA_W +: `DC_DATA_W] <= word_data;
        end
    end

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_valid,
    input  dcache_pkg::cpu_req_t             req,
    output logic                             busy,
    output logic                             done,
    output logic [`DC_DATA_W-1:0]            rdata,
    output logic                             hit_out,
    output logic [`DC_DATA_W-1:0]            lookup_addr,
    input  logic                             hit,
    input  logic                             hit_way,
    input  logic [`DC_DATA_W-1:0]            hit_word,
    input  logic                             victim_way,
    input  logic                             victim_dirty,
    input  logic [`DC_DATA_W-1:0]            victim_addr,
    input  logic [`DC_DATA_W*`DC_WORDS-1:0]  victim_block,
    output logic                             fill_en,
    output logic                             fill_way,
    output logic [`DC_DATA_W*`DC_WORDS-1:0]  fill_block,
    output logic                             fill_dirty,
    output logic                             word_wr_en,
    output logic                             word_way,
    output logic [`DC_DATA_W-1:0]            word_data,
    output dcache_pkg::access_size_e         size,
    output logic [1:0]                       byte_off,
    output logic [`DC_DATA_W-1:0]            word_in,
    output logic [`DC_DATA_W-1:0]            store_data,
    input  logic [`DC_DATA_W-1:0]            load_data,
    input  logic [`DC_DATA_W-1:0]            merged_word,
    output logic                             mem_strobe,
    output dcache_pkg::mem_req_t             mem_req,
    input  logic                             mem_done,
    input  logic [`DC_DATA_W*`DC_WORDS-1:0]  mem_rdata,
    output logic                             hit_pulse,
    output logic                             miss_pulse
);
    import dcache_pkg::*;

    ctrl_state_e state;
    cpu_req_t    req_q;
    logic        way_q;
    logic        hit_q;
    mem_req_t    wb_req;
    mem_req_t    rd_req;

    assign lookup_addr = req_q.addr;
    assign size        = req_q.size;
    assign byte_off    = req_q.addr[1:0];
    assign store_data  = req_q.wdata;
    assign word_in     = hit_word;

    assign hit_pulse  = (state == S_LOOKUP) && hit;
    assign miss_pulse = (state == S_LOOKUP) && !hit;

    // Fill lands on the edge that leaves S_REFILL, the store word on leaving S_DONE
    assign fill_en    = (state == S_REFILL) && mem_done;
    assign fill_way   = way_q;
    assign fill_block = mem_rdata;
    assign fill_dirty = (req_q.op == OP_STORE);
    assign word_wr_en = (state == S_DONE) && (req_q.op == OP_STORE);
    assign word_way   = way_q;
    assign word_data  = merged_word;

    always_comb begin
        wb_req.write = 1'b1;
        wb_req.addr  = victim_addr;
        wb_req.data  = victim_block;
        rd_req.write = 1'b0;
        rd_req.addr  = {req_q.addr[`DC_DATA_W-1:`DC_OFFSET_W+2], {(`DC_OFFSET_W+2){1'b0}}};
        rd_req.data  = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            mem_strobe <= 1'b0;
        end else begin
            done       <= 1'b0;
            mem_strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        busy  <= 1'b1;
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state <= S_DONE;
                    end else begin
                        mem_strobe <= 1'b1;
                        state      <= victim_dirty ? S_WRITEBACK : S_REFILL;
                    end
                end
                S_WRITEBACK: begin
                    if (mem_done) begin
                        mem_strobe <= 1'b1;
                        state      <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (mem_done) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == S_LOOKUP) begin
            way_q   <= hit ? hit_way : victim_way;
            hit_q   <= hit;
            mem_req <= victim_dirty ? wb_req : rd_req;
        end else if (state == S_WRITEBACK) begin
            mem_req <= rd_req;
        end
        if (state == S_DONE) begin
            rdata   <= (req_q.op == OP_LOAD) ? load_data : '0;
            hit_out <= hit_q;
        end
    end

endmodule

// File: dcache_stats.sv
`timescale 1ns/1ns

module dcache_stats (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        hit_pulse,
    input  logic        miss_pulse,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count
);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            // Counters stick at all ones
            if (hit_pulse && hit_count != '1) begin
                hit_count <= hit_count + 32'd1;
            end
            if (miss_pulse && miss_count != '1) begin
                miss_count <= miss_count + 32'd1;
            end
        end
    end

endmodule

// File: main_mem.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module main_mem (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             strobe,
    input  dcache_pkg::mem_req_t             req,
    output logic                             done,
    output logic [`DC_DATA_W*`DC_WORDS-1:0]  rdata
);
    import dcache_pkg::*;

    localparam int BLK_W = $clog2(`DC_MEM_BLOCKS);
    localparam int CNT_W = $clog2(`DC_MEM_LATENCY + 1);

    logic [`DC_DATA_W*`DC_WORDS-1:0] mem [`DC_MEM_BLOCKS];
    mem_req_t                        req_q;
    logic [CNT_W-1:0]                count;
    logic [BLK_W-1:0]                blk;

    // Each word holds its own byte address
    initial begin
        for (int b = 0; b < `DC_MEM_BLOCKS; b++) begin
            for (int w = 0; w < `DC_WORDS; w++) begin
                mem[b][w*`DC_DATA_W +: `DC_DATA_W] = b*`DC_WORDS*4 + w*4;
            end
        end
    end

    // Upper address bits are ignored, so the memory aliases
    assign blk   = req_q.addr[`DC_OFFSET_W+2 +: BLK_W];
    assign done  = (count == CNT_W'(1));
    assign rdata = mem[blk];

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (strobe) begin
            count <= CNT_W'(`DC_MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            req_q <= req;
        end
        if (done && req_q.write) begin
            mem[blk] <= req_q.data;
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  busy,
    output logic                  done,
    output logic [`DC_DATA_W-1:0] rdata,
    output logic                  hit,
    input  logic                  stats_clear,
    output logic [31:0]           hit_count,
    output logic [31:0]           miss_count
);
    import dcache_pkg::*;

    logic [`DC_DATA_W-1:0]            lookup_addr;
    logic                             arr_hit;
    logic                             hit_way;
    logic [`DC_DATA_W-1:0]            hit_word;
    logic                             victim_way;
    logic                             victim_dirty;
    logic [`DC_DATA_W-1:0]            victim_addr;
    logic [`DC_DATA_W*`DC_WORDS-1:0]  victim_block;
    logic                             fill_en;
    logic                             fill_way;
    logic [`DC_DATA_W*`DC_WORDS-1:0]  fill_block;
    logic                             fill_dirty;
    logic                             word_wr_en;
    logic                             word_way;
    logic [`DC_DATA_W-1:0]            word_data;
    access_size_e                     al_size;
    logic [1:0]                       al_byte_off;
    logic [`DC_DATA_W-1:0]            al_word_in;
    logic [`DC_DATA_W-1:0]            al_store_data;
    logic [`DC_DATA_W-1:0]            al_load_data;
    logic [`DC_DATA_W-1:0]            al_merged_word;
    logic                             mem_strobe;
    mem_req_t                         mem_req;
    logic                             mem_done;
    logic [`DC_DATA_W*`DC_WORDS-1:0]  mem_rdata;
    logic                             hit_pulse;
    logic                             miss_pulse;

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .hit_out      (hit),
        .lookup_addr  (lookup_addr),
        .hit          (arr_hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_block   (fill_block),
        .fill_dirty   (fill_dirty),
        .word_wr_en   (word_wr_en),
        .word_way     (word_way),
        .word_data    (word_data),
        .size         (al_size),
        .byte_off     (al_byte_off),
        .word_in      (al_word_in),
        .store_data   (al_store_data),
        .load_data    (al_load_data),
        .merged_word  (al_merged_word),
        .mem_strobe   (mem_strobe),
        .mem_req      (mem_req),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .hit_pulse    (hit_pulse),
        .miss_pulse   (miss_pulse)
    );

    dcache_arrays i_arrays (
        .clk          (clk),
        .reset        (reset),
        .lookup_addr  (lookup_addr),
        .hit          (arr_hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_block   (fill_block),
        .fill_dirty   (fill_dirty),
        .word_wr_en   (word_wr_en),
        .word_way     (word_way),
        .word_data    (word_data)
    );

    dcache_align i_align (
        .size        (al_size),
        .byte_off    (al_byte_off),
        .word_in     (al_word_in),
        .store_data  (al_store_data),
        .load_data   (al_load_data),
        .merged_word (al_merged_word)
    );

    dcache_stats i_stats (
        .clk        (clk),
        .reset      (reset),
        .clear      (stats_clear),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    main_mem i_mem (
        .clk    (clk),
        .reset  (reset),
        .strobe (mem_strobe),
        .req    (mem_req),
        .done   (mem_done),
        .rdata  (mem_rdata)
    );

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int FIELDS     = 6;
    localparam int MAX_REQS   = 64;
    localparam int DONE_WAIT  = 4 * (`DC_MEM_LATENCY + 1) + 10;
    localparam int HIT_CYCLES = 2;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    cpu_req_t              req;
    logic                  busy;
    logic                  done;
    logic [`DC_DATA_W-1:0] rdata;
    logic                  hit;
    logic                  stats_clear;
    logic [31:0]           hit_count;
    logic [31:0]           miss_count;

    // Six words per request, see the golden file header
    logic [31:0] golden [MAX_REQS*FIELDS];
    logic [31:0] rng_state;
    int          cur_req;
    int          hits_expected;
    int          misses_expected;

    dcache_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .done        (done),
        .rdata       (rdata),
        .hit         (hit),
        .stats_clear (stats_clear),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    always begin
        #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at request %0d", cur_req);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h (request %0d)",
                                        name, actual, expected, cur_req));
        end
    endtask

    // Counts falling edges until done shows up
    task automatic wait_for_done(output int cycles);
        int   waited;
        logic done_seen;
        waited    = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            waited++;
            if (done) begin
                done_seen = 1'b1;
            end else if (waited >= DONE_WAIT) begin
                stop_with_failure($sformatf("Timeout: no done for request %0d", cur_req));
            end
        end
        cycles = waited;
    endtask

    task automatic run_request(input int idx);
        int base;
        int gap;
        int cycles;
        base = idx * FIELDS;
        cur_req = idx;
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[1:0]);
        // A few idle cycles between requests
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req.op     = cpu_op_e'(golden[base][0]);
        req.size   = access_size_e'(golden[base+1][2:0]);
        req.addr   = golden[base+2];
        req.wdata  = golden[base+3];
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req       = '0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h1);
        wait_for_done(cycles);
        check_value("rdata", rdata, golden[base+4]);
        check_value("hit", 32'(hit), golden[base+5]);
        check_value("busy", 32'(busy), 32'h0);
        if (golden[base+5][0]) begin
            check_value("hit latency", 32'(cycles), 32'(HIT_CYCLES));
            hits_expected++;
        end else begin
            misses_expected++;
        end
    endtask

    initial begin
        int n_reqs;
        clk             = 1'b0;
        reset           = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        stats_clear     = 1'b0;
        rng_state       = 32'h53bd3097;
        cur_req         = -1;
        hits_expected   = 0;
        misses_expected = 0;
        for (int i = 0; i < MAX_REQS * FIELDS; i++) begin
            golden[i] = '1;
        end
        $readmemh("dcache_golden.txt", golden);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h0);
        check_value("done", 32'(done), 32'h0);
        check_value("hit_count", hit_count, 32'h0);
        check_value("miss_count", miss_count, 32'h0);

        // All ones in the op word marks the end of the table
        n_reqs = 0;
        while (n_reqs < MAX_REQS && golden[n_reqs*FIELDS] != 32'hffff_ffff) begin
            run_request(n_reqs);
            n_reqs++;
        end
        if (n_reqs == 0) begin
            stop_with_failure("No requests could be read from dcache_golden.txt");
        end

        cur_req = n_reqs;
        @(negedge clk);
        check_value("hit_count", hit_count, 32'(hits_expected));
        check_value("miss_count", miss_count, 32'(misses_expected));

        @(posedge clk);
        #1;
        stats_clear = 1'b1;
        @(posedge clk);
        #1;
        stats_clear = 1'b0;
        @(negedge clk);
        check_value("hit_count", hit_count, 32'h0);
        check_value("miss_count", miss_count, 32'h0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
dcache_pkg.sv
dcache_align.sv
dcache_arrays.sv
dcache_ctrl.sv
dcache_stats.sv
main_mem.sv
dcache_top.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# Build the data-cache testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dcache -f files.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1
[ -f sim.log ] && cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: dcache_golden.txt
// op size addr wdata expected_rdata expected_hit, all hex
// op 0 load 1 store; size is funct3 (0 B, 1 H, 2 W, 4 BU, 5 HU)
// Cold loads, memory words hold their own address
0 2 00000080 00000000 00000080 0
0 0 00000080 00000000 ffffff80 1
0 4 00000080 00000000 00000080 1
0 1 00000084 00000000 00000084 1
0 5 00000086 00000000 00000000 1
0 1 000001f0 00000000 000001f0 0
0 4 000001f1 00000000 00000001 1
0 0 000000f0 00000000 fffffff0 0
0 2 000000fc 00000000 000000fc 1
// Stores then loads of the same address
1 2 00000084 deadbeef 00000000 1
0 2 00000084 00000000 deadbeef 1
1 0 00000089 000000a5 00000000 1
0 2 00000088 00000000 0000a588 1
0 0 00000089 00000000 ffffffa5 1
1 1 0000008e 00008001 00000000 1
0 1 0000008e 00000000 ffff8001 1
0 5 0000008e 00000000 00008001 1
0 2 0000008c 00000000 8001008c 1
1 0 00000203 0000007f 00000000 0
0 2 00000200 00000000 7f000200 1
// Set 0x10, three clean blocks in round-robin order
0 2 00000100 00000000 00000100 0
0 2 00000904 00000000 00000904 0
0 2 00000108 00000000 00000108 1
0 2 00001100 00000000 00001100 0
0 2 00000908 00000000 00000908 1
0 2 0000010c 00000000 0000010c 0
0 2 00001104 00000000 00001104 1
0 2 00000900 00000000 00000900 0
// Set 0x08, dirty block 0x80 written back and reloaded
0 2 00000880 00000000 00000880 0
0 2 00001084 00000000 00001084 0
0 2 00000084 00000000 deadbeef 0
0 2 00000088 00000000 0000a588 1
0 1 0000008e 00000000 ffff8001 1
0 2 00004088 00000000 0000a588 0
// Set 0x20, store-miss blocks evicted dirty
1 2 00000a00 12345678 00000000 0
0 2 00001200 00000000 00001200 0
0 2 00000a00 00000000 12345678 1
0 2 00001a04 00000000 00001a04 0
0 2 00000200 00000000 7f000200 0
0 2 00000a00 00000000 12345678 0
